// File: Makefile
# Verilator build for the video capture testbench

VERILATOR ?= verilator
TOP       ?= tb_video_capture
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
rtl/vidcap_pkg.sv
rtl/pixel_packer.sv
rtl/line_tracker.sv
rtl/line_framer.sv
rtl/video_capture_top.sv
tests/tb_clock_gen.sv
tests/tb_video_capture.sv

// File: rtl/line_framer.sv
`timescale 1ns/1ps
`default_nettype none

module line_framer import vidcap_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,

    input  wire  [WORD_W-1:0]  pack_word_i,
    input  wire                pack_we_i,

    input  wire  [FRAME_W-1:0] frame_no_i,
    input  wire  [LINE_W-1:0]  line_no_i,
    input  wire                line_start_i,

    output logic [WORD_W-1:0]  word_o,
    output logic               word_we_o,
    output logic               sop_o
);

    cap_word_t next_word;

    // header and payload strobes never fall in the same cycle
    always_comb begin
        if (line_start_i) begin
            next_word.hdr.tag   = LINE_TAG;
            next_word.hdr.frame = frame_no_i;
            next_word.hdr.line  = line_no_i;
        end else begin
            next_word.raw = pack_word_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            word_we_o <= 1'b0;
            sop_o     <= 1'b0;
        end else begin
            word_we_o <= line_start_i || pack_we_i;
            // start of packet marks the header word only
            sop_o     <= line_start_i;
        end
    end

    always_ff @(posedge clk) begin
        if (line_start_i || pack_we_i) begin
            word_o <= next_word.raw;
        end
    end

endmodule

`default_nettype wire

// File: rtl/line_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module line_tracker import vidcap_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,

    input  wire                vid_de_i,
    input  wire                vid_vsync_i,

    output logic [FRAME_W-1:0] frame_no_o,
    output logic [LINE_W-1:0]  line_no_o,
    output logic               line_start_o
);

    logic de_q;
    logic vsync_q;

    logic de_rise;
    logic de_fall;
    logic vsync_rise;

    assign de_rise    = vid_de_i && !de_q;
    assign de_fall    = !vid_de_i && de_q;
    assign vsync_rise = vid_vsync_i && !vsync_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            de_q         <= 1'b0;
            vsync_q      <= 1'b0;
            line_start_o <= 1'b0;
        end else begin
            de_q         <= vid_de_i;
            vsync_q      <= vid_vsync_i;
            line_start_o <= de_rise;
        end
    end

    // counters change only on vsync rise or de fall, so they are stable
    // while line_start_o is high
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            frame_no_o <= '0;
            line_no_o  <= '0;
        end else if (vsync_rise) begin
            frame_no_o <= frame_no_o + 1'b1;
            line_no_o  <= '0;
        end else if (de_fall) begin
            line_no_o <= line_no_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_packer import vidcap_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,

    input  wire                vid_de_i,
    input  wire  [PIXEL_W-1:0] vid_data_i,

    output logic [WORD_W-1:0]  pack_word_o,
    output logic               pack_we_o
);

    // bytes left over from the previous pixel with the oldest in the low byte
    logic [PIXEL_W-1:0] pend_bytes;
    logic [1:0]         byte_cnt;
    logic               de_q;

    logic [PIXEL_W-1:0]        pend_valid;
    logic [WORD_W+PIXEL_W-1:0] merged;
    logic [2:0]                total_cnt;
    logic                      word_full;
    logic                      line_end;

    // bytes above byte_cnt are stale and must not leak into the merge
    assign pend_valid = pend_bytes & ~({PIXEL_W{1'b1}} << (byte_cnt * BYTE_W));

    // new pixel lands right above the pending bytes
    assign merged = {{WORD_W{1'b0}}, pend_valid} |
                    ({{WORD_W{1'b0}}, vid_data_i} << (byte_cnt * BYTE_W));

    assign total_cnt = {1'b0, byte_cnt} + 3'(BYTES_PER_PIX);
    assign word_full = vid_de_i && (total_cnt >= 3'(BYTES_PER_WORD));

    // first blank cycle after an active run
    assign line_end = !vid_de_i && de_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            de_q      <= 1'b0;
            byte_cnt  <= 2'd0;
            pack_we_o <= 1'b0;
        end else begin
            de_q      <= vid_de_i;
            pack_we_o <= 1'b0;
            if (vid_de_i) begin
                if (word_full) begin
                    pack_we_o <= 1'b1;
                    byte_cnt  <= 2'(total_cnt - 3'(BYTES_PER_WORD));
                end else begin
                    byte_cnt <= 2'(total_cnt);
                end
            end else if (line_end) begin
                // flush only if something is still held
                pack_we_o <= (byte_cnt != 2'd0);
                byte_cnt  <= 2'd0;
            end
        end
    end

    // output word and pending byte registers
    always_ff @(posedge clk) begin
        if (vid_de_i) begin
            if (word_full) begin
                pack_word_o <= merged[WORD_W-1:0];
                pend_bytes  <= merged[WORD_W +: PIXEL_W];
            end else begin
                pend_bytes <= merged[PIXEL_W-1:0];
            end
        end else if (line_end) begin
            // remainder goes out with the upper bytes zero
            pack_word_o <= {{(WORD_W-PIXEL_W){1'b0}}, pend_valid};
        end
    end

endmodule

`default_nettype wire

// File: rtl/vidcap_pkg.sv
package vidcap_pkg;

    // video and stream widths
    localparam int PIXEL_W = 24;
    localparam int BYTE_W  = 8;
    localparam int WORD_W  = 32;

    // header field widths
    localparam int FRAME_W = 8;
    localparam int LINE_W  = 16;

    // byte counts derived from the widths above
    localparam int BYTES_PER_PIX  = PIXEL_W / BYTE_W;
    localparam int BYTES_PER_WORD = WORD_W / BYTE_W;

    // marker in the top byte of every header word
    localparam logic [BYTE_W-1:0] LINE_TAG = 8'hA5;

    // header word layout, msb first
    typedef struct packed {
        logic [BYTE_W-1:0]  tag;
        logic [FRAME_W-1:0] frame;
        logic [LINE_W-1:0]  line;
    } cap_hdr_t;

    // one output word, seen either as a header or as raw payload bytes
    typedef union packed {
        cap_hdr_t          hdr;
        logic [WORD_W-1:0] raw;
    } cap_word_t;

endpackage

// File: rtl/video_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_capture_top import vidcap_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,

    // pixel stream
    input  wire                vid_de_i,
    input  wire                vid_vsync_i,
    input  wire  [PIXEL_W-1:0] vid_data_i,

    // word stream towards the udp sender
    output logic [WORD_W-1:0]  word_o,
    output logic               word_we_o,
    output logic               sop_o
);

    logic [WORD_W-1:0]  pack_word;
    logic               pack_we;

    logic [FRAME_W-1:0] frame_no;
    logic [LINE_W-1:0]  line_no;
    logic               line_start;

    // payload bytes
    pixel_packer pixel_packer_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .vid_de_i    (vid_de_i),
        .vid_data_i  (vid_data_i),
        .pack_word_o (pack_word),
        .pack_we_o   (pack_we)
    );

    // frame and line numbering, runs alongside the packer
    line_tracker line_tracker_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .vid_de_i     (vid_de_i),
        .vid_vsync_i  (vid_vsync_i),
        .frame_no_o   (frame_no),
        .line_no_o    (line_no),
        .line_start_o (line_start)
    );

    line_framer line_framer_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pack_word_i  (pack_word),
        .pack_we_i    (pack_we),
        .frame_no_i   (frame_no),
        .line_no_i    (line_no),
        .line_start_i (line_start),
        .word_o       (word_o),
        .word_we_o    (word_we_o),
        .sop_o        (sop_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // release on a falling edge so the first active edge sees a clean level
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: tests/tb_video_capture.sv
`timescale 1ns/1ps

module tb_video_capture import vidcap_pkg::*; ();

    localparam int SEED        = 16898;
    localparam int IDLE_CYCLES = 20;
    localparam int VSYNC_HIGH  = 3;
    localparam int VSYNC_LOW   = 3;
    localparam int DRAIN_EXTRA = 8;

    // line lengths in pixels for each test
    localparam int PACK_LENS [5]  = '{4, 5, 6, 7, 16};
    localparam int PACK_BLANK     = 4;
    localparam int COUNT_LENS [5] = '{8, 8, 8, 5, 5};
    localparam int COUNT_BLANK    = 4;
    localparam int MIN_LENS [6]   = '{4, 5, 6, 7, 16, 4};
    localparam int MIN_BLANK      = 2;

    logic               clk;
    logic               rst_n;
    logic               vid_de;
    logic               vid_vsync;
    logic [PIXEL_W-1:0] vid_data;
    logic [WORD_W-1:0]  word;
    logic               word_we;
    logic               sop;

    // reference model state
    logic [WORD_W-1:0]  exp_word_q [$];
    bit                 exp_sop_q [$];
    int                 exp_count_q [$];
    logic [PIXEL_W-1:0] line_pix [$];
    logic [7:0]         ref_frame;
    logic [15:0]        ref_line;
    int                 line_words;

    int err_count;
    int pass_count;
    int fail_count;
    int cycle_count;
    int cycle_limit;

    tb_clock_gen #(
        .PERIOD_NS    (8.0),
        .RESET_CYCLES (16)
    ) tb_clock_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    video_capture_top video_capture_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .vid_de_i    (vid_de),
        .vid_vsync_i (vid_vsync),
        .vid_data_i  (vid_data),
        .word_o      (word),
        .word_we_o   (word_we),
        .sop_o       (sop)
    );

    function automatic int stim_cycles();
        int total;
        int i;
        total = IDLE_CYCLES + 3 * (VSYNC_HIGH + VSYNC_LOW);
        for (i = 0; i < $size(PACK_LENS); i++) begin
            total += PACK_LENS[i] + PACK_BLANK;
        end
        for (i = 0; i < $size(COUNT_LENS); i++) begin
            total += COUNT_LENS[i] + COUNT_BLANK;
        end
        for (i = 0; i < $size(MIN_LENS); i++) begin
            total += MIN_LENS[i] + MIN_BLANK;
        end
        return total;
    endfunction

    // checks the word count of the line just ended against 1 + ceil(3N/4)
    task automatic close_line_count();
        int exp_n;
        if (line_words != 0) begin
            if (exp_count_q.size() == 0) begin
                $display("line of %0d words arrived but no line was sent (%0t)",
                         line_words, $time);
                err_count++;
            end else begin
                exp_n = exp_count_q.pop_front();
                assert (line_words == exp_n)
                    else begin
                        $display("** Error (%0t): line had %0d words, expected %0d",
                                 $time, line_words, exp_n);
                        err_count++;
                    end
            end
        end
        line_words = 0;
    endtask

    // header from the frame and line counts, then the pixel bytes packed low byte first
    task automatic expect_line(input int n);
        cap_word_t         hdr;
        logic [BYTE_W-1:0] bytes [$];
        logic [WORD_W-1:0] w;
        int                i;
        int                k;
        hdr.raw       = '0;
        hdr.hdr.tag   = 8'hA5;
        hdr.hdr.frame = ref_frame;
        hdr.hdr.line  = ref_line;
        exp_word_q.push_back(hdr.raw);
        exp_sop_q.push_back(1'b1);
        for (i = 0; i < n; i++) begin
            bytes.push_back(line_pix[i][7:0]);
            bytes.push_back(line_pix[i][15:8]);
            bytes.push_back(line_pix[i][23:16]);
        end
        while (bytes.size() > 0) begin
            w = '0;
            for (k = 0; k < 4 && bytes.size() > 0; k++) begin
                w[k*8 +: 8] = bytes.pop_front();
            end
            exp_word_q.push_back(w);
            exp_sop_q.push_back(1'b0);
        end
        exp_count_q.push_back(1 + (3 * n + 3) / 4);
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            vid_de   = 1'b0;
            vid_data = '0;
        end
    endtask

    task automatic drive_line(input int n, input int blank);
        int i;
        line_pix.delete();
        for (i = 0; i < n; i++) begin
            line_pix.push_back(PIXEL_W'($urandom()));
        end
        expect_line(n);
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            vid_de   = 1'b1;
            vid_data = line_pix[i];
        end
        drive_idle(blank);
        // falling de counts the line
        ref_line = ref_line + 16'd1;
    endtask

    task automatic drive_vsync();
        repeat (VSYNC_HIGH) begin
            @(negedge clk);
            vid_vsync = 1'b1;
        end
        repeat (VSYNC_LOW) begin
            @(negedge clk);
            vid_vsync = 1'b0;
        end
        ref_frame = ref_frame + 8'd1;
        ref_line  = '0;
    endtask

    // waits for every expected word, then a few more cycles for stray words
    task automatic wait_drain();
        while (exp_word_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (DRAIN_EXTRA) @(posedge clk);
        close_line_count();
        if (exp_count_q.size() != 0) begin
            $display("%0d lines never arrived (%0t)", exp_count_q.size(), $time);
            err_count++;
            exp_count_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        wait_drain();
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic run_idle_test();
        int errs_before;
        errs_before = err_count;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            vid_de    = 1'b0;
            vid_vsync = 1'b0;
            assert (!word_we && !sop)
                else begin
                    $display("** Error (%0t): output strobe while inputs idle", $time);
                    err_count++;
                end
        end
        finish_test("idle after reset", errs_before);
    endtask

    task automatic run_packing_test();
        int errs_before;
        int i;
        errs_before = err_count;
        for (i = 0; i < $size(PACK_LENS); i++) begin
            drive_line(PACK_LENS[i], PACK_BLANK);
        end
        finish_test("packing line lengths", errs_before);
    endtask

    task automatic run_count_test();
        int errs_before;
        int i;
        errs_before = err_count;
        for (i = 0; i < $size(COUNT_LENS); i++) begin
            // two frames, three lines then two
            if (i == 0 || i == 3) begin
                drive_vsync();
            end
            drive_line(COUNT_LENS[i], COUNT_BLANK);
        end
        finish_test("frame and line counting", errs_before);
    endtask

    task automatic run_min_blank_test();
        int errs_before;
        int i;
        errs_before = err_count;
        drive_vsync();
        for (i = 0; i < $size(MIN_LENS); i++) begin
            drive_line(MIN_LENS[i], MIN_BLANK);
        end
        finish_test("minimum blanking", errs_before);
    endtask

    // compares every written word with the head of the expected queue
    always @(negedge clk) begin : word_monitor
        cap_word_t got;
        cap_word_t want;
        bit        want_sop;
        if (rst_n && word_we) begin
            got.raw = word;
            if (exp_word_q.size() == 0) begin
                $display("unexpected word %h with nothing left to send (%0t)", word, $time);
                err_count++;
            end else begin
                want.raw = exp_word_q.pop_front();
                want_sop = exp_sop_q.pop_front();
                assert (sop === want_sop)
                    else begin
                        $display("** Error (%0t): sop_o %b, expected %b", $time, sop, want_sop);
                        err_count++;
                    end
                if (want_sop) begin
                    assert (got.hdr.tag === 8'hA5 && got.hdr.frame === want.hdr.frame &&
                            got.hdr.line === want.hdr.line)
                        else begin
                            $display("** Error (%0t): header %h/%0d/%0d, expected a5/%0d/%0d",
                                     $time, got.hdr.tag, got.hdr.frame, got.hdr.line,
                                     want.hdr.frame, want.hdr.line);
                            err_count++;
                        end
                end else begin
                    assert (got.raw === want.raw)
                        else begin
                            $display("** Error (%0t): payload %h, expected %h",
                                     $time, got.raw, want.raw);
                            err_count++;
                        end
                end
            end
            if (sop) begin
                close_line_count();
            end
            line_words++;
        end
    end

    initial begin
        cycle_count = 0;
        cycle_limit = 2 * stim_cycles() + 200;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles, %0d words still expected",
                     cycle_count, exp_word_q.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        vid_de     = 1'b0;
        vid_vsync  = 1'b0;
        vid_data   = '0;
        ref_frame  = '0;
        ref_line   = '0;
        line_words = 0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(SEED));

        @(posedge rst_n);
        run_idle_test();
        run_packing_test();
        run_count_test();
        run_min_blank_test();

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
